//--- Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/l1i_pkg.sv
      - verilog/l1i_if.sv
      - verilog/l1i_cache.sv
      - verilog/fetch_ctrl.sv
      - verilog/fetch_stage.sv
  - target: test
    files:
      - bench/fetch_checker.sv
      - bench/fetch_tb.sv

//--- bench/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker
  import cpu_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst,
  input wire logic  ready_o,
  input wire logic  valid_o,
  input wire word_t inst_o,
  input wire logic  next_ready_i,
  input wire logic  bus_arvalid_o,
  input wire addr_t bus_araddr_o
);

  // The request address may only move once the request has dropped.
  araddr_stable: assert property (@(posedge clk) disable iff (rst)
    (bus_arvalid_o && $past(bus_arvalid_o)) |-> $stable(bus_araddr_o))
  else $error("bus_araddr_o changed while bus_arvalid_o was high");

  out_held: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> (valid_o && $stable(inst_o)))
  else $error("valid_o or inst_o changed while next_ready_i was low");

  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    !(ready_o && valid_o))
  else $error("ready_o and valid_o high in the same cycle");

endmodule

bind fetch_ctrl fetch_checker u_checker (
  .clk           (clk),
  .rst           (rst),
  .ready_o       (ready_o),
  .valid_o       (valid_o),
  .inst_o        (inst_o),
  .next_ready_i  (next_ready_i),
  .bus_arvalid_o (bus_arvalid_o),
  .bus_araddr_o  (bus_araddr_o)
);

`default_nettype wire

//--- bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import cpu_pkg::*;
  import l1i_pkg::*;
();

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 5;
  localparam int FETCH_BUDGET = 50; // Well above the fetches issued by all tests.
  localparam int CYCLES_PER_FETCH = 100; // Worst bus delay plus stall, with wide margin.
  localparam int WATCHDOG_NS = FETCH_BUDGET * CYCLES_PER_FETCH * CLK_PERIOD_NS;
  localparam int RESP_LIMIT = 40; // Cycles to wait for valid_o after an accept.
  localparam int unsigned SEED = 32'h525edd33;
  localparam word_t MEM_PATTERN = 32'ha5a5a5a5;
  localparam addr_t ADDR_A = 32'h0000_1040;
  localparam addr_t ADDR_C = 32'h0000_3004;
  localparam addr_t FENCE_ADDR = 32'h0000_2008;

  logic  clk;
  logic  rst;
  logic  prev_valid_i;
  addr_t npc_i;
  logic  ready_o;
  logic  next_ready_i;
  logic  valid_o;
  word_t inst_o;
  addr_t pc_o;
  addr_t bus_araddr_o;
  logic  bus_arvalid_o;
  word_t bus_rdata_i;
  logic  bus_rvalid_i;

  word_t       preload_mem [addr_t]; // Words that override the address pattern.
  int unsigned delay_q [$];
  int          req_count = 0;
  logic        arvalid_q = 1'b0;
  int          check_count = 0;
  int          err_count = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name;

  fetch_stage dut0 (
    .clk           (clk),
    .rst           (rst),
    .prev_valid_i  (prev_valid_i),
    .npc_i         (npc_i),
    .ready_o       (ready_o),
    .next_ready_i  (next_ready_i),
    .valid_o       (valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_rvalid_i  (bus_rvalid_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  function automatic word_t expected_word(addr_t a);
    return a ^ MEM_PATTERN;
  endfunction

  function automatic word_t model_word(addr_t a);
    if (preload_mem.exists(a))
      return preload_mem[a];
    return a ^ MEM_PATTERN;
  endfunction

  // Bus memory. One request at a time, answered after a drawn delay.
  initial
  begin
    addr_t       req_addr;
    int unsigned delay;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    forever
    begin
      @(negedge clk);
      if (bus_arvalid_o)
      begin
        req_addr = bus_araddr_o;
        delay = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        bus_rvalid_i <= 1'b1;
        bus_rdata_i  <= model_word(req_addr);
        @(posedge clk);
        bus_rvalid_i <= 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (bus_arvalid_o && !arvalid_q)
      req_count++;
    arvalid_q = bus_arvalid_o;
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic check_flag(input bit ok, input string what);
    check_count++;
    assert (ok)
    else
    begin
      $display("ERR %0t: %s", $time, what);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    tests_run++;
  endtask

  task automatic report_test();
    if (test_errs == 0)
      $display("test %-18s passed", test_name);
    else
    begin
      $display("test %-18s failed with %0d mismatches", test_name, test_errs);
      tests_failed++;
    end
  endtask

  // Hands one address over and waits for valid_o, without taking the result.
  task automatic fetch_wait(input addr_t addr, output word_t inst, output addr_t pc,
                            output int lat);
    @(posedge clk);
    prev_valid_i <= 1'b1;
    npc_i        <= addr;
    @(negedge clk);
    while (!ready_o)
      @(negedge clk);
    @(posedge clk); // Accepting edge.
    prev_valid_i <= 1'b0;
    lat = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end
    while (!valid_o && lat < RESP_LIMIT);
    if (!valid_o)
    begin
      $display("fetch of %h got no valid_o within %0d cycles", addr, RESP_LIMIT);
      err_count++;
      test_errs++;
    end
    inst = inst_o;
    pc   = pc_o;
    check_word(pc, addr, "pc_o");
  endtask

  task automatic fetch_check(input addr_t addr, input word_t exp_inst, input int exp_reqs,
                             output int lat);
    word_t inst;
    addr_t pc;
    int    reqs_before;
    reqs_before = req_count;
    fetch_wait(addr, inst, pc, lat);
    check_word(inst, exp_inst, $sformatf("inst_o for %h", addr));
    check_flag(req_count - reqs_before == exp_reqs,
               $sformatf("fetch of %h made %0d bus requests, expected %0d",
                         addr, req_count - reqs_before, exp_reqs));
    @(posedge clk); // next_ready_i is high, so the result leaves here.
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    @(negedge clk);
    check_flag(ready_o === 1'b1, "ready_o is not high after reset");
    check_flag(valid_o === 1'b0, "valid_o is not low after reset");
    check_flag(bus_arvalid_o === 1'b0, "bus_arvalid_o is not low after reset");
    report_test();
  endtask

  task automatic test_cold_miss();
    int lat;
    start_test("cold_miss");
    fetch_check(ADDR_A, expected_word(ADDR_A), 1, lat);
    report_test();
  endtask

  task automatic test_hit();
    int lat;
    start_test("hit");
    fetch_check(ADDR_A, expected_word(ADDR_A), 0, lat);
    check_flag(lat == 2, $sformatf("hit took %0d cycles after accept, expected 2", lat));
    report_test();
  endtask

  task automatic test_conflict_uncached();
    int lat;
    start_test("conflict_uncached");
    fetch_check(ADDR_A + 32, expected_word(ADDR_A + 32), 1, lat); // Same index as ADDR_A.
    fetch_check(ADDR_A, expected_word(ADDR_A), 1, lat);
    fetch_check(ADDR_A, expected_word(ADDR_A), 0, lat);
    fetch_check(MMIO_LO, expected_word(MMIO_LO), 1, lat);
    fetch_check(MMIO_LO, expected_word(MMIO_LO), 1, lat);
    fetch_check(MMIO_HI, expected_word(MMIO_HI), 1, lat);
    fetch_check(MMIO_HI, expected_word(MMIO_HI), 1, lat);
    report_test();
  endtask

  task automatic test_fence_flush();
    int lat;
    start_test("fence_flush");
    preload_mem[FENCE_ADDR] = FENCE_I_WORD;
    fetch_check(ADDR_C, expected_word(ADDR_C), 1, lat);
    fetch_check(ADDR_C, expected_word(ADDR_C), 0, lat);
    fetch_check(ADDR_A, expected_word(ADDR_A), 0, lat);
    fetch_check(FENCE_ADDR, FENCE_I_WORD, 1, lat);
    // Everything cached before the fence.i must come from the bus again.
    fetch_check(ADDR_C, expected_word(ADDR_C), 1, lat);
    fetch_check(ADDR_A, expected_word(ADDR_A), 1, lat);
    fetch_check(FENCE_ADDR, FENCE_I_WORD, 1, lat);
    report_test();
  endtask

  task automatic test_back_pressure();
    addr_t addr;
    word_t inst;
    addr_t pc;
    int    lat;
    int    hold;
    addr = 32'h0000_4010;
    hold = $urandom_range(8, 1);
    start_test("back_pressure");
    @(posedge clk);
    next_ready_i <= 1'b0;
    fetch_wait(addr, inst, pc, lat);
    check_word(inst, expected_word(addr), "inst_o under back-pressure");
    repeat (hold)
    begin
      @(posedge clk);
      @(negedge clk);
      check_flag(valid_o && !ready_o, "valid_o dropped or ready_o rose during a stall");
      check_word(inst_o, inst, "stalled inst_o");
      check_word(pc_o, pc, "stalled pc_o");
    end
    @(posedge clk);
    next_ready_i <= 1'b1;
    @(negedge clk);
    check_flag(valid_o && !ready_o, "result left before next_ready_i was seen");
    @(posedge clk);
    @(negedge clk);
    check_flag(ready_o && !valid_o, "ready_o not back after the transfer");
    report_test();
  endtask

  initial
  begin
    void'($urandom(SEED));
    repeat (64) delay_q.push_back($urandom_range(5, 0));
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    npc_i        = '0;
    next_ready_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_cold_miss();
    test_hit();
    test_conflict_uncached();
    test_fence_flush();
    test_back_pressure();
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/cpu_pkg.sv
verilog/l1i_pkg.sv
verilog/l1i_if.sv
verilog/l1i_cache.sv
verilog/fetch_ctrl.sv
verilog/fetch_stage.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Width of the architectural registers, fetch addresses and bus words.
  localparam int unsigned XLEN = 32;

  // Every instruction is one aligned 32-bit word, as compressed forms are not supported.
  localparam int unsigned INST_BYTES = 4;

  typedef logic [XLEN-1:0] addr_t; // Byte address of an instruction.
  typedef logic [XLEN-1:0] word_t; // Instruction or bus data word.

  // Fetch resumes from here after reset.
  localparam addr_t RESET_PC = 32'h8000_0000;

  // Canonical nop, addi x0, x0, 0.
  localparam word_t NOP_WORD = 32'h0000_0013;

  // MISC-MEM opcode with funct3 of 001.
  // Seeing this word in the fetch stream invalidates the instruction cache.
  localparam word_t FENCE_I_WORD = 32'h0000_100f;

endpackage

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
  import cpu_pkg::*;
  import l1i_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  // Previous stage.
  input  wire logic  prev_valid_i,
  input  wire addr_t npc_i,
  output logic       ready_o,

  // Next stage.
  input  wire logic  next_ready_i,
  output logic       valid_o,
  output word_t      inst_o,
  output addr_t      pc_o,

  // Instruction bus read channel.
  output addr_t      bus_araddr_o,
  output logic       bus_arvalid_o,
  input  wire word_t bus_rdata_i,
  input  wire logic  bus_rvalid_i,

  l1i_if.ctrl        l1i
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t        pc_q;
  word_t        inst_q;

  logic accept;
  logic lookup_hit;
  logic bus_done;
  logic out_done;

  assign accept     = (state_q == FS_IDLE) && prev_valid_i;
  assign lookup_hit = (state_q == FS_LOOKUP) && l1i.hit;
  assign bus_done   = (state_q == FS_BUS) && bus_rvalid_i;
  assign out_done   = (state_q == FS_RESP) && next_ready_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FS_IDLE:
      begin
        if (accept)
          state_d = FS_LOOKUP;
      end
      FS_LOOKUP:
      begin
        // Uncached addresses never hit, so they fall through to the bus.
        if (lookup_hit)
          state_d = FS_RESP;
        else
          state_d = FS_BUS;
      end
      FS_BUS:
      begin
        if (bus_done)
          state_d = FS_RESP;
      end
      FS_RESP:
      begin
        if (out_done)
          state_d = FS_IDLE;
      end
      default:
        state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= FS_IDLE;
    else
      state_q <= state_d;
  end

  // The pc is held from accept until the next accept.
  always_ff @(posedge clk)
  begin
    if (rst)
      pc_q <= RESET_PC;
    else if (accept)
      pc_q <= npc_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      inst_q <= NOP_WORD;
    else if (lookup_hit)
      inst_q <= l1i.hit_data;
    else if (bus_done)
      inst_q <= bus_rdata_i; // Same edge as the cache fill.
  end

  // Only one fetch is ever in flight.
  assign ready_o = (state_q == FS_IDLE);
  assign valid_o = (state_q == FS_RESP);
  assign inst_o  = inst_q;
  assign pc_o    = pc_q;

  // The request stays up, with its address, until the response pulse.
  assign bus_arvalid_o = (state_q == FS_BUS);
  assign bus_araddr_o  = pc_q;

  assign l1i.lookup_addr = pc_q;
  assign l1i.fill_en     = bus_done;
  assign l1i.fill_data   = bus_rdata_i;
  assign l1i.flush       = bus_done && (bus_rdata_i == FENCE_I_WORD);

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import cpu_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  // Fetch address from the previous stage.
  input  wire logic  prev_valid_i,
  input  wire addr_t npc_i,
  output logic       ready_o,

  // Instruction and its pc toward decode.
  input  wire logic  next_ready_i,
  output logic       valid_o,
  output word_t      inst_o,
  output addr_t      pc_o,

  // Single-word read bus.
  output addr_t      bus_araddr_o,
  output logic       bus_arvalid_o,
  input  wire word_t bus_rdata_i,
  input  wire logic  bus_rvalid_i
);

  // Lookup and fill path between the controller and the cache.
  l1i_if l1i_bus ();

  fetch_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .prev_valid_i  (prev_valid_i),
    .npc_i         (npc_i),
    .ready_o       (ready_o),
    .next_ready_i  (next_ready_i),
    .valid_o       (valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .l1i           (l1i_bus.ctrl)
  );

  l1i_cache u_cache (
    .clk (clk),
    .rst (rst),
    .l1i (l1i_bus.cache)
  );

endmodule

`default_nettype wire

//--- verilog/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1i_cache
  import cpu_pkg::*;
  import l1i_pkg::*;
(
  input wire logic clk,
  input wire logic rst,
  l1i_if.cache     l1i
);

  tag_t                 tag_q   [L1I_LINES];
  word_t                data_q  [L1I_LINES];
  logic [L1I_LINES-1:0] valid_q;

  idx_t lk_idx;
  tag_t lk_tag;
  logic lk_uncached;
  logic line_valid;
  logic tag_match;
  logic fill_write;

  // Split the fetch address into index and tag.
  assign lk_idx = l1i.lookup_addr[L1I_OFF_W +: L1I_IDX_W];
  assign lk_tag = l1i.lookup_addr[XLEN-1 -: L1I_TAG_W];

  // Device window. Reads here must always reach the bus.
  assign lk_uncached = (l1i.lookup_addr >= MMIO_LO) && (l1i.lookup_addr <= MMIO_HI);

  assign line_valid = valid_q[lk_idx];
  assign tag_match  = (tag_q[lk_idx] == lk_tag);

  // The lookup is answered in the same cycle.
  assign l1i.hit      = line_valid && tag_match && !lk_uncached;
  assign l1i.hit_data = data_q[lk_idx];

  // A fill lands on the line of the address still on lookup_addr.
  // A fence.i word is not stored since the flush wipes the cache anyway.
  assign fill_write = l1i.fill_en && !l1i.flush && !lk_uncached;

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_q <= '0;
    else if (l1i.flush)
      valid_q <= '0; // Invalidate every line at once.
    else if (fill_write)
      valid_q[lk_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (fill_write)
    begin
      tag_q[lk_idx]  <= lk_tag;
      data_q[lk_idx] <= l1i.fill_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/l1i_if.sv
`timescale 1ns/1ps
`default_nettype none

interface l1i_if
  import cpu_pkg::*;
();

  // Address being fetched. It also addresses the fill.
  addr_t lookup_addr;

  // Lookup result, valid in the same cycle as lookup_addr.
  logic  hit;
  word_t hit_data;

  // Line write from a completed bus read.
  logic  fill_en;
  word_t fill_data;

  // Clears every valid bit and takes priority over fill_en.
  logic  flush;

  modport ctrl (
    output lookup_addr,
    output fill_en,
    output fill_data,
    output flush,
    input  hit,
    input  hit_data
  );

  modport cache (
    input  lookup_addr,
    input  fill_en,
    input  fill_data,
    input  flush,
    output hit,
    output hit_data
  );

endinterface

`default_nettype wire

//--- verilog/l1i_pkg.sv
`default_nettype none

package l1i_pkg;

  // Direct mapped, one instruction word per line.
  localparam int unsigned L1I_LINES = 8;
  localparam int unsigned L1I_IDX_W = $clog2(L1I_LINES);

  // Byte offset within a word, then the index, then the tag.
  localparam int unsigned L1I_OFF_W = $clog2(cpu_pkg::INST_BYTES);
  localparam int unsigned L1I_TAG_W = cpu_pkg::XLEN - L1I_IDX_W - L1I_OFF_W;

  typedef logic [L1I_IDX_W-1:0] idx_t; // Address bits 4 to 2.
  typedef logic [L1I_TAG_W-1:0] tag_t; // Address bits 31 to 5.

  // Device window that is never cached. Both bounds lie inside it.
  localparam cpu_pkg::addr_t MMIO_LO = 32'h0f00_0000;
  localparam cpu_pkg::addr_t MMIO_HI = 32'h0f00_2000;

  // FS_LOOKUP is the single cycle spent reading the cache.
  typedef enum logic [1:0] {
    FS_IDLE,
    FS_LOOKUP,
    FS_BUS,
    FS_RESP
  } fetch_state_t;

endpackage

`default_nettype wire
